/* common/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    localparam int xlen = 32; // Data and address width

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        op_reg   = 7'b0110011, // Register-register ALU class
        op_imm   = 7'b0010011, // Register-immediate ALU class
        op_load  = 7'b0000011,
        op_store = 7'b0100011
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_sll  = 4'd2,
        alu_slt  = 4'd3,
        alu_sltu = 4'd4,
        alu_xor  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_or   = 4'd8,
        alu_and  = 4'd9
    } alu_op_e;

    // funct7 value that turns add into sub and srl into sra
    localparam logic [6:0] funct7_alt = 7'b0100000;

    // funct3 codes of the ALU classes
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    // funct3 of lw and sw, the only sizes handled
    localparam logic [2:0] f3_word    = 3'b010;

endpackage

`default_nettype wire

/* common/cpu_ctrl_if.sv */
`default_nettype none

// Decoded control bundle, decoder to datapath
interface cpu_ctrl_if;

    rv_pkg::reg_addr_t rs1_addr;
    rv_pkg::reg_addr_t rs2_addr;
    rv_pkg::reg_addr_t rd_addr;
    logic              rd_we;     // Never set for x0
    rv_pkg::alu_op_e   alu_op;
    logic              use_imm;   // Operand B from imm
    rv_pkg::word_t     imm;       // Sign-extended I or S immediate
    logic              mem_read;  // Write-back from memory
    logic              mem_write;

    modport decoder (
        output rs1_addr, rs2_addr, rd_addr, rd_we,
        output alu_op, use_imm, imm,
        output mem_read, mem_write
    );

    modport regs (
        input rs1_addr, rs2_addr, rd_addr, rd_we, mem_read
    );

    modport exec (
        input alu_op, use_imm, imm
    );

    modport mem (
        input mem_read, mem_write
    );

endinterface

`default_nettype wire

/* memory/fetch_unit.sv */
`default_nettype none

module fetch_unit #(
    parameter int unsigned imem_words = 64
) (
    input  wire logic                          CLK,
    input  wire logic                          RST,
    input  wire logic                          run,
    input  wire logic                          load_en,
    input  wire logic [$clog2(imem_words)-1:0] load_addr,
    input  wire rv_pkg::word_t                 load_data,
    output rv_pkg::word_t                      instr,
    output rv_pkg::word_t                      retire_pc
);

    localparam int unsigned imem_aw = $clog2(imem_words);

    // Byte address of the last word, where the PC wraps
    localparam rv_pkg::word_t last_pc = rv_pkg::word_t'((imem_words - 1) * 4);

    rv_pkg::word_t pc;
    rv_pkg::word_t pc_next;
    rv_pkg::word_t imem [imem_words];

    assign pc_next = (pc == last_pc) ? '0 : pc + rv_pkg::word_t'(4);

    assign instr = imem[pc[imem_aw+1:2]]; // Word index of the PC

    always_ff @(posedge CLK) begin
        if (RST) begin
            pc <= '0;
        end else if (run) begin
            pc <= pc_next;
        end
    end

    // Program load port, used while run is low
    always_ff @(posedge CLK) begin
        if (load_en) begin
            imem[load_addr] <= load_data;
        end
    end

    // PC of the instruction that just executed
    always_ff @(posedge CLK) begin
        if (run) begin
            retire_pc <= pc;
        end
    end

endmodule

`default_nettype wire

/* memory/data_mem.sv */
`default_nettype none

module data_mem #(
    parameter int unsigned dmem_words = 64
) (
    input  wire logic          CLK,
    input  wire logic          run,
    cpu_ctrl_if.mem            ctrl,
    input  wire rv_pkg::word_t addr,       // Byte address from the ALU
    input  wire rv_pkg::word_t store_data,
    output rv_pkg::word_t      load_data
);

    localparam int unsigned dmem_aw = $clog2(dmem_words);

    rv_pkg::word_t             mem [dmem_words];
    logic [dmem_aw-1:0]        word_idx;

    // Byte offset bits and bits above the depth are ignored
    assign word_idx = addr[dmem_aw+1:2];

    assign load_data = ctrl.mem_read ? mem[word_idx] : '0; // Quiet when not loading

    always_ff @(posedge CLK) begin
        if (run && ctrl.mem_write) begin
            mem[word_idx] <= store_data;
        end
    end

endmodule

`default_nettype wire

/* verilog/instr_decoder.sv */
`default_nettype none

module instr_decoder (
    input  wire rv_pkg::word_t instr,
    cpu_ctrl_if.decoder        ctrl
);

    logic [6:0]        opcode;
    logic [2:0]        funct3;
    logic [6:0]        funct7;
    rv_pkg::reg_addr_t rd;
    rv_pkg::word_t     imm_i;
    rv_pkg::word_t     imm_s;
    rv_pkg::alu_op_e   reg_op;
    rv_pkg::alu_op_e   imm_op;

    // Maps funct3 to an ALU operation; sub only exists in the register class
    function automatic rv_pkg::alu_op_e alu_from_funct3(
        input logic [2:0] f3,
        input logic       alt,
        input logic       is_reg
    );
        rv_pkg::alu_op_e op;
        case (f3)
            rv_pkg::f3_add_sub: op = (alt && is_reg) ? rv_pkg::alu_sub : rv_pkg::alu_add;
            rv_pkg::f3_sll:     op = rv_pkg::alu_sll;
            rv_pkg::f3_slt:     op = rv_pkg::alu_slt;
            rv_pkg::f3_sltu:    op = rv_pkg::alu_sltu;
            rv_pkg::f3_xor:     op = rv_pkg::alu_xor;
            rv_pkg::f3_srl_sra: op = alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
            rv_pkg::f3_or:      op = rv_pkg::alu_or;
            default:            op = rv_pkg::alu_and;
        endcase
        return op;
    endfunction

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rd     = instr[11:7];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]}; // Split store offset

    // srai carries funct7_alt in the upper immediate bits
    assign reg_op = alu_from_funct3(funct3, funct7 == rv_pkg::funct7_alt, 1'b1);
    assign imm_op = alu_from_funct3(funct3, funct7 == rv_pkg::funct7_alt, 1'b0);

    assign ctrl.rs1_addr = instr[19:15];
    assign ctrl.rs2_addr = instr[24:20];
    assign ctrl.rd_addr  = rd;

    always_comb begin
        ctrl.rd_we     = 1'b0; // Unknown encodings fall through as no-ops
        ctrl.alu_op    = rv_pkg::alu_add;
        ctrl.use_imm   = 1'b0;
        ctrl.imm       = imm_i;
        ctrl.mem_read  = 1'b0;
        ctrl.mem_write = 1'b0;

        case (opcode)
            rv_pkg::op_reg: begin
                ctrl.rd_we  = 1'b1;
                ctrl.alu_op = reg_op;
            end
            rv_pkg::op_imm: begin
                ctrl.rd_we   = 1'b1;
                ctrl.alu_op  = imm_op;
                ctrl.use_imm = 1'b1;
            end
            rv_pkg::op_load: begin
                if (funct3 == rv_pkg::f3_word) begin
                    ctrl.rd_we    = 1'b1;
                    ctrl.use_imm  = 1'b1; // Address is rs1 + offset
                    ctrl.mem_read = 1'b1;
                end
            end
            rv_pkg::op_store: begin
                if (funct3 == rv_pkg::f3_word) begin
                    ctrl.use_imm   = 1'b1;
                    ctrl.imm       = imm_s;
                    ctrl.mem_write = 1'b1;
                end
            end
            default: ;
        endcase

        if (rd == '0) begin
            ctrl.rd_we = 1'b0; // x0 stays zero
        end
    end

endmodule

`default_nettype wire

/* verilog/alu.sv */
`default_nettype none

module alu (
    cpu_ctrl_if.exec           ctrl,
    input  wire rv_pkg::word_t rs1_data,
    input  wire rv_pkg::word_t rs2_data,
    output rv_pkg::word_t      result
);

    rv_pkg::word_t op_b;
    logic [4:0]    shamt;

    assign op_b  = ctrl.use_imm ? ctrl.imm : rs2_data;
    assign shamt = op_b[4:0]; // Only the low five bits shift

    always_comb begin
        case (ctrl.alu_op)
            rv_pkg::alu_add: begin
                result = rs1_data + op_b;
            end
            rv_pkg::alu_sub: begin
                result = rs1_data - op_b;
            end
            rv_pkg::alu_sll: begin
                result = rs1_data << shamt;
            end
            rv_pkg::alu_slt: begin
                result = {31'd0, $signed(rs1_data) < $signed(op_b)};
            end
            rv_pkg::alu_sltu: begin
                result = {31'd0, rs1_data < op_b};
            end
            rv_pkg::alu_xor: begin
                result = rs1_data ^ op_b;
            end
            rv_pkg::alu_srl: begin
                result = rs1_data >> shamt;
            end
            rv_pkg::alu_sra: begin
                result = rv_pkg::word_t'($signed(rs1_data) >>> shamt); // Keeps sign
            end
            rv_pkg::alu_or: begin
                result = rs1_data | op_b;
            end
            rv_pkg::alu_and: begin
                result = rs1_data & op_b;
            end
            default: begin
                result = rs1_data + op_b;
            end
        endcase
    end

endmodule

`default_nettype wire

/* verilog/register_file.sv */
`default_nettype none

module register_file (
    input  wire logic          CLK,
    input  wire logic          RST,
    input  wire logic          run,
    cpu_ctrl_if.regs           ctrl,
    input  wire rv_pkg::word_t alu_result,
    input  wire rv_pkg::word_t load_data,
    output rv_pkg::word_t      rs1_data,
    output rv_pkg::word_t      rs2_data,
    output logic               retire_valid,
    output logic               retire_we,
    output rv_pkg::reg_addr_t  retire_rd,
    output rv_pkg::word_t      retire_data
);

    rv_pkg::word_t regs [1:31]; // x0 has no storage
    rv_pkg::word_t wb_data;

    assign rs1_data = (ctrl.rs1_addr == '0) ? '0 : regs[ctrl.rs1_addr];
    assign rs2_data = (ctrl.rs2_addr == '0) ? '0 : regs[ctrl.rs2_addr];

    assign wb_data = ctrl.mem_read ? load_data : alu_result;

    always_ff @(posedge CLK) begin
        if (run && ctrl.rd_we) begin
            regs[ctrl.rd_addr] <= wb_data; // Decoder never sets rd_we for x0
        end
    end

    // Retire report, one cycle behind execution
    always_ff @(posedge CLK) begin
        if (RST) begin
            retire_valid <= 1'b0;
            retire_we    <= 1'b0;
        end else begin
            retire_valid <= run;
            retire_we    <= run & ctrl.rd_we;
        end
    end

    always_ff @(posedge CLK) begin
        if (run) begin
            retire_rd   <= ctrl.rd_addr;
            retire_data <= wb_data;
        end
    end

endmodule

`default_nettype wire

/* verilog/cpu_top.sv */
`default_nettype none

module cpu_top #(
    parameter int unsigned imem_words = 64,
    parameter int unsigned dmem_words = 64
) (
    input  wire logic                          CLK,
    input  wire logic                          RST,
    input  wire logic                          run,
    input  wire logic                          load_en,
    input  wire logic [$clog2(imem_words)-1:0] load_addr,
    input  wire rv_pkg::word_t                 load_data,
    output logic                               retire_valid,
    output rv_pkg::word_t                      retire_pc,
    output logic                               retire_we,
    output rv_pkg::reg_addr_t                  retire_rd,
    output rv_pkg::word_t                      retire_data
);

    rv_pkg::word_t instr;
    rv_pkg::word_t rs1_data;
    rv_pkg::word_t rs2_data;
    rv_pkg::word_t alu_result; // Also the data address
    rv_pkg::word_t mem_rdata;

    cpu_ctrl_if ctrl ();

    fetch_unit #(.imem_words(imem_words)) u_fetch (
        .CLK      (CLK),
        .RST      (RST),
        .run      (run),
        .load_en  (load_en),
        .load_addr(load_addr),
        .load_data(load_data),
        .instr    (instr),
        .retire_pc(retire_pc)
    );

    instr_decoder u_decoder (.instr(instr), .ctrl(ctrl.decoder));

    register_file u_regs (
        .CLK         (CLK),
        .RST         (RST),
        .run         (run),
        .ctrl        (ctrl.regs),
        .alu_result  (alu_result),
        .load_data   (mem_rdata),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .retire_valid(retire_valid),
        .retire_we   (retire_we),
        .retire_rd   (retire_rd),
        .retire_data (retire_data)
    );

    alu u_alu (
        .ctrl    (ctrl.exec),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .result  (alu_result)
    );

    data_mem #(.dmem_words(dmem_words)) u_dmem (
        .CLK       (CLK),
        .run       (run),
        .ctrl      (ctrl.mem),
        .addr      (alu_result),
        .store_data(rs2_data),
        .load_data (mem_rdata)
    );

endmodule

`default_nettype wire

/* tests/cpu_tb.sv */
`default_nettype none

module cpu_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int imem_words = 64;
    localparam int dmem_words = 64;
    localparam int n_rows     = 26;
    localparam int limit      = 16 + n_rows + n_rows + 20; // Reset, load, run, slack

    localparam logic [6:0] opc_reg   = 7'b0110011;
    localparam logic [6:0] opc_imm   = 7'b0010011;
    localparam logic [6:0] opc_load  = 7'b0000011;
    localparam logic [6:0] opc_store = 7'b0100011;

    logic        CLK = 1'b0;
    logic        RST;
    logic        run;
    logic        load_en;
    logic [5:0]  load_addr;
    logic [31:0] load_data;
    logic        retire_valid;
    logic [31:0] retire_pc;
    logic        retire_we;
    logic [4:0]  retire_rd;
    logic [31:0] retire_data;

    // Program and expected retire values, one row per instruction
    string       row_name [n_rows];
    logic [31:0] row_instr [n_rows];
    logic        row_we [n_rows];
    logic [4:0]  row_rd [n_rows];
    logic [31:0] row_data [n_rows];
    int          row_cnt = 0;
    int unsigned cycles = 0;

    cpu_top #(.imem_words(imem_words), .dmem_words(dmem_words)) DUT (
        .CLK         (CLK),
        .RST         (RST),
        .run         (run),
        .load_en     (load_en),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .retire_valid(retire_valid),
        .retire_pc   (retire_pc),
        .retire_we   (retire_we),
        .retire_rd   (retire_rd),
        .retire_data (retire_data)
    );

    always #20 CLK = ~CLK;

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("Timeout: the retire port stopped reporting instructions");
            $display("Something failed");
            $fatal(1);
        end
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, opc_reg};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opc_store};
    endfunction

    task automatic add_row(input string nm, input logic [31:0] ins, input logic we,
                           input logic [4:0] rd, input logic [31:0] data);
        row_name[row_cnt]  = nm;
        row_instr[row_cnt] = ins;
        row_we[row_cnt]    = we;
        row_rd[row_cnt]    = rd;
        row_data[row_cnt]  = data;
        row_cnt++;
    endtask

    task automatic build_table(input logic [11:0] imm_a, input logic [11:0] imm_b);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [11:0] imm_c;
        logic [4:0]  sh;
        imm_c = 12'h8a5; // Negative immediate for the I-type group
        sh    = 5'd7;
        a     = sext12(imm_a);
        b     = sext12(imm_b);
        c     = sext12(imm_c);
        add_row("addi a", enc_i(imm_a, 5'd0, 3'b000, 5'd1, opc_imm), 1'b1, 5'd1, a);
        add_row("addi b", enc_i(imm_b, 5'd0, 3'b000, 5'd2, opc_imm), 1'b1, 5'd2, b);
        add_row("add", enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), 1'b1, 5'd3, a + b);
        add_row("sub", enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd4), 1'b1, 5'd4, a - b);
        add_row("sll", enc_r(7'h00, 5'd2, 5'd1, 3'b001, 5'd5), 1'b1, 5'd5, a << b[4:0]);
        add_row("slt", enc_r(7'h00, 5'd2, 5'd1, 3'b010, 5'd6), 1'b1, 5'd6,
                {31'd0, $signed(a) < $signed(b)});
        add_row("sltu", enc_r(7'h00, 5'd2, 5'd1, 3'b011, 5'd7), 1'b1, 5'd7, {31'd0, a < b});
        add_row("xor", enc_r(7'h00, 5'd2, 5'd1, 3'b100, 5'd8), 1'b1, 5'd8, a ^ b);
        add_row("srl", enc_r(7'h00, 5'd1, 5'd2, 3'b101, 5'd9), 1'b1, 5'd9, b >> a[4:0]);
        add_row("sra", enc_r(7'h20, 5'd1, 5'd2, 3'b101, 5'd10), 1'b1, 5'd10,
                32'($signed(b) >>> a[4:0]));
        add_row("or", enc_r(7'h00, 5'd2, 5'd1, 3'b110, 5'd11), 1'b1, 5'd11, a | b);
        add_row("and", enc_r(7'h00, 5'd2, 5'd1, 3'b111, 5'd12), 1'b1, 5'd12, a & b);
        add_row("addi", enc_i(imm_c, 5'd1, 3'b000, 5'd13, opc_imm), 1'b1, 5'd13, a + c);
        add_row("slti", enc_i(imm_c, 5'd2, 3'b010, 5'd14, opc_imm), 1'b1, 5'd14,
                {31'd0, $signed(b) < $signed(c)});
        add_row("sltiu", enc_i(imm_c, 5'd1, 3'b011, 5'd15, opc_imm), 1'b1, 5'd15,
                {31'd0, a < c});
        add_row("xori", enc_i(imm_c, 5'd1, 3'b100, 5'd16, opc_imm), 1'b1, 5'd16, a ^ c);
        add_row("ori", enc_i(imm_c, 5'd1, 3'b110, 5'd17, opc_imm), 1'b1, 5'd17, a | c);
        add_row("andi", enc_i(imm_c, 5'd1, 3'b111, 5'd18, opc_imm), 1'b1, 5'd18, a & c);
        add_row("slli", enc_i({7'h00, sh}, 5'd1, 3'b001, 5'd19, opc_imm), 1'b1, 5'd19, a << sh);
        add_row("srli", enc_i({7'h00, sh}, 5'd2, 3'b101, 5'd20, opc_imm), 1'b1, 5'd20, b >> sh);
        add_row("srai", enc_i({7'h20, sh}, 5'd2, 3'b101, 5'd21, opc_imm), 1'b1, 5'd21,
                32'($signed(b) >>> sh));
        add_row("sw", enc_s(12'd8, 5'd2, 5'd0), 1'b0, 5'd0, 32'd0); // Store to byte 8
        add_row("lw", enc_i(12'd8, 5'd0, 3'b010, 5'd22, opc_load), 1'b1, 5'd22, b);
        add_row("addi x0", enc_i(12'd5, 5'd1, 3'b000, 5'd0, opc_imm), 1'b0, 5'd0, 32'd0);
        add_row("read x0", enc_r(7'h00, 5'd0, 5'd0, 3'b000, 5'd23), 1'b1, 5'd23, 32'd0);
        add_row("unknown", 32'h123450b7, 1'b0, 5'd0, 32'd0); // lui is not decoded
    endtask

    initial begin
        logic [11:0] imm_a;
        logic [11:0] imm_b;
        RST       = 1'b1;
        run       = 1'b0;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        void'($urandom(60));
        imm_a     = 12'($urandom);
        imm_b     = 12'($urandom) | 12'h800; // Always negative
        build_table(imm_a, imm_b);
        check("table size", n_rows, row_cnt);

        repeat (16) @(posedge CLK);
        #2;
        RST = 1'b0;
        check("valid after reset", 32'd0, {31'd0, retire_valid});
        check("we after reset", 32'd0, {31'd0, retire_we});

        for (int i = 0; i < n_rows; i++) begin
            load_en   = 1'b1;
            load_addr = 6'(i);
            load_data = row_instr[i];
            @(posedge CLK);
            #2;
        end
        load_en = 1'b0;
        check("valid while loading", 32'd0, {31'd0, retire_valid});
        run = 1'b1;
        @(posedge CLK); // First instruction executes here

        // One retire per cycle, each one cycle after its instruction
        for (int i = 0; i < n_rows; i++) begin
            @(negedge CLK);
            check({row_name[i], " valid"}, 32'd1, {31'd0, retire_valid});
            check({row_name[i], " pc"}, 32'(i * 4), retire_pc);
            check({row_name[i], " we"}, {31'd0, row_we[i]}, {31'd0, retire_we});
            if (row_we[i]) begin
                check({row_name[i], " rd"}, {27'd0, row_rd[i]}, {27'd0, retire_rd});
                check({row_name[i], " data"}, row_data[i], retire_data);
            end
        end

        @(posedge CLK);
        #2;
        run = 1'b0;
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

/* single_cpu.f */
common/rv_pkg.sv
common/cpu_ctrl_if.sv
memory/fetch_unit.sv
memory/data_mem.sv
verilog/instr_decoder.sv
verilog/alu.sv
verilog/register_file.sv
verilog/cpu_top.sv
tests/cpu_tb.sv

/* Bender.yml */
package:
  name: single_cpu

sources:
  # Shared package and control bundle
  - common/rv_pkg.sv
  - common/cpu_ctrl_if.sv
  # Memories and program counter
  - memory/fetch_unit.sv
  - memory/data_mem.sv
  # Control and datapath
  - verilog/instr_decoder.sv
  - verilog/alu.sv
  - verilog/register_file.sv
  - verilog/cpu_top.sv
  # Testbench
  - target: test
    files:
      - tests/cpu_tb.sv
